// File: rv_pkg.sv
package rv_pkg;

  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6  // lui hands the u immediate straight through
  } alu_op_e;

  typedef enum logic [1:0] {
    CSR_MCAUSE  = 2'd0,
    CSR_MEPC    = 2'd1,
    CSR_MSTATUS = 2'd2,
    CSR_MTVEC   = 2'd3
  } csr_idx_e;

  localparam logic [11:0] ADDR_MCAUSE  = 12'h342;
  localparam logic [11:0] ADDR_MEPC    = 12'h341;
  localparam logic [11:0] ADDR_MSTATUS = 12'h300;
  localparam logic [11:0] ADDR_MTVEC   = 12'h305;

  localparam logic [2:0] F3_ADD   = 3'b000;  // also sub, told apart by funct7
  localparam logic [2:0] F3_SLT   = 3'b010;
  localparam logic [2:0] F3_XOR   = 3'b100;
  localparam logic [2:0] F3_OR    = 3'b110;
  localparam logic [2:0] F3_AND   = 3'b111;
  localparam logic [2:0] F3_BEQ   = 3'b000;
  localparam logic [2:0] F3_BNE   = 3'b001;
  localparam logic [2:0] F3_CSRRW = 3'b001;
  localparam logic [2:0] F3_CSRRS = 3'b010;
  localparam logic [6:0] F7_BASE  = 7'b0000000;
  localparam logic [6:0] F7_SUB   = 7'b0100000;

  localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;
  localparam logic [31:0] INSTR_MRET  = 32'h3020_0073;

  localparam logic [31:0] RESET_PC        = 32'h0000_0000;
  localparam logic [4:0]  ECALL_CAUSE_REG = 5'd17;  // a7 holds the call number

endpackage

// File: alu.sv
`timescale 1ns/10ps

module alu (
  input  logic [31:0]     a,
  input  logic [31:0]     b,
  input  rv_pkg::alu_op_e alu_op,
  output logic [31:0]     result,
  output logic            eq
);
  import rv_pkg::*;

  logic lt;

  assign lt = $signed(a) < $signed(b);  // slt compares as two's complement
  assign eq = (a == b);  // branch condition when b carries rs2

  always_comb begin
    case (alu_op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      ALU_SLT: begin
        result = {31'b0, lt};
      end
      ALU_PASS_B: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: decoder.sv
`timescale 1ns/10ps

module decoder (
  input  logic [31:0]      instr,
  output logic [4:0]       rs1,
  output logic [4:0]       rs2,
  output logic [4:0]       rd,
  output logic [31:0]      imm,
  output rv_pkg::alu_op_e  alu_op,
  output logic             use_imm,
  output logic             reg_write_en,
  output rv_pkg::csr_idx_e csr_rs,
  output rv_pkg::csr_idx_e csr_rd,
  output logic             csreg_write_en,
  output logic             csr_set,
  output logic             wb_csr,
  output logic             ecall,
  output logic             mret,
  output logic             branch,
  output logic             branch_ne
);
  import rv_pkg::*;

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic [31:0] imm_b;
  csr_idx_e    csr_idx;
  logic        csr_hit;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

  // the same csr is read for the old value and written with the new one
  assign csr_rs = csr_idx;
  assign csr_rd = csr_idx;

  always_comb begin
    csr_hit = 1'b1;
    case (instr[31:20])
      ADDR_MCAUSE:  csr_idx = CSR_MCAUSE;
      ADDR_MEPC:    csr_idx = CSR_MEPC;
      ADDR_MSTATUS: csr_idx = CSR_MSTATUS;
      ADDR_MTVEC:   csr_idx = CSR_MTVEC;
      default: begin
        csr_idx = CSR_MCAUSE;
        csr_hit = 1'b0;  // unknown csr turns the instruction into a no-op
      end
    endcase
  end

  always_comb begin
    imm            = '0;
    alu_op         = ALU_ADD;
    use_imm        = 1'b0;
    reg_write_en   = 1'b0;
    csreg_write_en = 1'b0;
    csr_set        = 1'b0;
    wb_csr         = 1'b0;
    ecall          = 1'b0;
    mret           = 1'b0;
    branch         = 1'b0;
    branch_ne      = 1'b0;
    case (opcode)
      OP_IMM: begin
        if (funct3 == F3_ADD) begin  // only addi is implemented
          imm          = imm_i;
          use_imm      = 1'b1;
          reg_write_en = 1'b1;
        end
      end
      OP: begin
        if (funct7 == F7_BASE) begin
          reg_write_en = 1'b1;
          case (funct3)
            F3_ADD:  alu_op = ALU_ADD;
            F3_SLT:  alu_op = ALU_SLT;
            F3_XOR:  alu_op = ALU_XOR;
            F3_OR:   alu_op = ALU_OR;
            F3_AND:  alu_op = ALU_AND;
            default: reg_write_en = 1'b0;
          endcase
        end else if (funct7 == F7_SUB && funct3 == F3_ADD) begin
          alu_op       = ALU_SUB;
          reg_write_en = 1'b1;
        end
      end
      LUI: begin
        imm          = imm_u;
        alu_op       = ALU_PASS_B;
        use_imm      = 1'b1;
        reg_write_en = 1'b1;
      end
      BRANCH: begin
        imm       = imm_b;
        branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        branch_ne = (funct3 == F3_BNE);
      end
      SYSTEM: begin
        if (instr == INSTR_ECALL) begin
          ecall = 1'b1;
        end else if (instr == INSTR_MRET) begin
          mret = 1'b1;
        end else if (csr_hit && (funct3 == F3_CSRRW || funct3 == F3_CSRRS)) begin
          reg_write_en   = 1'b1;
          csreg_write_en = 1'b1;
          wb_csr         = 1'b1;
          csr_set        = (funct3 == F3_CSRRS);
        end
      end
      default: ;
    endcase
  end

endmodule

// File: wbu.sv
`timescale 1ns/10ps

module wbu (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [4:0]       rs1,
  input  logic [4:0]       rs2,
  input  rv_pkg::csr_idx_e csr_rs,
  input  logic [4:0]       rd,
  input  rv_pkg::csr_idx_e csr_rd,
  input  logic [31:0]      wd,
  input  logic [31:0]      csr_wd,
  input  logic             reg_write_en,
  input  logic             csreg_write_en,
  input  logic             ecall,
  output logic [31:0]      rsa,
  output logic [31:0]      rsb,
  output logic [31:0]      csra,
  output logic [31:0]      mtvec,
  output logic [31:0]      mepc
);
  import rv_pkg::*;

  logic [31:0] regs [32];
  logic [31:0] csrs [4];  // indexed by csr_idx_e

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
      for (int j = 0; j < 4; j++) begin
        csrs[j] <= '0;
      end
    end else begin
      if (reg_write_en && rd != 5'd0) begin  // x0 stays at its reset value of zero
        regs[rd] <= wd;
      end
      if (csreg_write_en) begin
        csrs[csr_rd] <= csr_wd;
      end
      if (ecall) begin  // overrides a csr write to mcause in the same cycle
        csrs[CSR_MCAUSE] <= regs[ECALL_CAUSE_REG];
      end
    end
  end

  assign rsa  = regs[rs1];
  assign rsb  = regs[rs2];
  assign csra = csrs[csr_rs];

  // trap and return targets go to the pc unit without using the csr read port
  assign mtvec = csrs[CSR_MTVEC];
  assign mepc  = csrs[CSR_MEPC];

endmodule

// File: pc_unit.sv
`timescale 1ns/10ps

module pc_unit (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        branch,
  input  logic        branch_ne,
  input  logic        eq,
  input  logic        ecall,
  input  logic        mret,
  input  logic [31:0] imm,
  input  logic [31:0] mtvec,
  input  logic [31:0] mepc,
  output logic [31:0] pc
);
  import rv_pkg::*;

  logic        taken;
  logic [31:0] pc_next;

  assign taken = branch && (branch_ne ? !eq : eq);

  always_comb begin
    if (ecall) begin
      pc_next = mtvec;
    end else if (mret) begin
      pc_next = mepc;
    end else if (taken) begin
      pc_next = pc + imm;  // b immediate is relative to the branch itself
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// File: rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] instr,
  output logic [31:0] pc,
  output logic        wb_en,
  output logic [4:0]  wb_rd,
  output logic [31:0] wb_data
);
  import rv_pkg::*;

  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic [31:0] imm;
  alu_op_e     alu_op;
  logic        use_imm;
  logic        reg_write_en;
  csr_idx_e    csr_rs;
  csr_idx_e    csr_rd;
  logic        csreg_write_en;
  logic        csr_set;
  logic        wb_csr;
  logic        ecall;
  logic        mret;
  logic        branch;
  logic        branch_ne;
  logic [31:0] rsa;
  logic [31:0] rsb;
  logic [31:0] csra;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] alu_b;
  logic [31:0] result;
  logic        eq;
  logic [31:0] wd;
  logic [31:0] csr_wd;

  decoder u_decoder (.instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .alu_op(alu_op), .use_imm(use_imm), .reg_write_en(reg_write_en), .csr_rs(csr_rs),
    .csr_rd(csr_rd), .csreg_write_en(csreg_write_en), .csr_set(csr_set), .wb_csr(wb_csr),
    .ecall(ecall), .mret(mret), .branch(branch), .branch_ne(branch_ne));

  assign alu_b = use_imm ? imm : rsb;

  alu u_alu (.a(rsa), .b(alu_b), .alu_op(alu_op), .result(result), .eq(eq));

  assign wd     = wb_csr ? csra : result;  // csr instructions return the old csr value
  assign csr_wd = csr_set ? (rsa | csra) : rsa;

  wbu u_wbu (.clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .csr_rs(csr_rs), .rd(rd),
    .csr_rd(csr_rd), .wd(wd), .csr_wd(csr_wd), .reg_write_en(reg_write_en),
    .csreg_write_en(csreg_write_en), .ecall(ecall), .rsa(rsa), .rsb(rsb), .csra(csra),
    .mtvec(mtvec), .mepc(mepc));

  pc_unit u_pc_unit (.clk(clk), .rst_n(rst_n), .branch(branch), .branch_ne(branch_ne),
    .eq(eq), .ecall(ecall), .mret(mret), .imm(imm), .mtvec(mtvec), .mepc(mepc), .pc(pc));

  // nothing retires while the core is held in reset
  assign wb_en   = reg_write_en && rst_n;
  assign wb_rd   = rd;
  assign wb_data = wd;

endmodule

// File: tb_model.svh
  // architectural state of the reference model
  logic [31:0] m_regs [32];
  logic [31:0] m_csrs [4];
  logic [31:0] m_pc;

  function automatic void model_reset();
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      m_csrs[i] = '0;
    end
    m_pc = RESET_PC;
  endfunction

  function automatic int csr_slot(input logic [11:0] addr);
    case (addr)
      ADDR_MCAUSE:  return int'(CSR_MCAUSE);
      ADDR_MEPC:    return int'(CSR_MEPC);
      ADDR_MSTATUS: return int'(CSR_MSTATUS);
      ADDR_MTVEC:   return int'(CSR_MTVEC);
      default:      return -1;
    endcase
  endfunction

  // executes one instruction at m_pc and gives back what the core should show for it
  function automatic void exec_step(input logic [31:0] ins, output logic [31:0] e_pc,
                                    output logic e_en, output logic [4:0] e_rd,
                                    output logic [31:0] e_data);
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_b;
    logic [31:0] nxt;
    int          slot;
    f3     = ins[14:12];
    a      = m_regs[ins[19:15]];
    b      = m_regs[ins[24:20]];
    imm_b  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    slot   = csr_slot(ins[31:20]);
    e_pc   = m_pc;
    e_en   = 1'b0;
    e_rd   = ins[11:7];
    e_data = '0;
    nxt    = m_pc + 32'd4;
    case (ins[6:0])
      OP_IMM: begin
        e_en   = (f3 == 3'b000);  // addi only
        e_data = a + {{20{ins[31]}}, ins[31:20]};
      end
      OP: begin
        e_en = 1'b1;
        case ({ins[31:25], f3})
          {7'h00, 3'b000}: e_data = a + b;
          {7'h20, 3'b000}: e_data = a - b;
          {7'h00, 3'b010}: e_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          {7'h00, 3'b100}: e_data = a ^ b;
          {7'h00, 3'b110}: e_data = a | b;
          {7'h00, 3'b111}: e_data = a & b;
          default:         e_en = 1'b0;
        endcase
      end
      LUI: begin
        e_en   = 1'b1;
        e_data = {ins[31:12], 12'b0};
      end
      BRANCH: begin
        if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
          nxt = m_pc + imm_b;
        end
      end
      SYSTEM: begin
        if (ins == 32'h0000_0073) begin  // ecall
          m_csrs[CSR_MCAUSE] = m_regs[ECALL_CAUSE_REG];
          nxt = m_csrs[CSR_MTVEC];
        end else if (ins == 32'h3020_0073) begin  // mret
          nxt = m_csrs[CSR_MEPC];
        end else if (slot >= 0 && (f3 == 3'b001 || f3 == 3'b010)) begin
          e_en         = 1'b1;
          e_data       = m_csrs[slot];
          m_csrs[slot] = (f3 == 3'b010) ? (a | e_data) : a;  // csrrs sets bits, csrrw replaces
        end
      end
      default: ;
    endcase
    if (e_en && e_rd != 5'd0) begin
      m_regs[e_rd] = e_data;
    end
    m_pc = nxt;
  endfunction

// File: tb_core.sv
`timescale 1ns/10ps

module tb_core;
  import rv_pkg::*;

  `include "tb_model.svh"

  logic        clk;
  logic        rst_n;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  logic [31:0] prog [512];
  int          test_of [512];  // which test each program word belongs to
  int          prog_len;
  logic [31:0] end_addr;
  logic        check_valid;
  logic [31:0] exp_pc;
  logic        exp_wb_en;
  logic [4:0]  exp_wb_rd;
  logic [31:0] exp_wb_data;
  int          exp_test;
  int          checks [6];
  int          errors [6];
  int          cycles;
  int          cycle_limit;
  string       test_names [6] = '{"reset", "alu", "x0 access", "csr", "trap", "branch"};

  rv_core uut (.clk(clk), .rst_n(rst_n), .instr(instr), .pc(pc), .wb_en(wb_en),
    .wb_rd(wb_rd), .wb_data(wb_data));

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  function automatic logic [31:0] r_type(input logic [2:0] f3, input logic [6:0] f7,
                                         input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] fetch(input logic [31:0] addr);
    if (addr < end_addr) begin
      return prog[addr[10:2]];
    end
    return 32'h0000_0013;  // nop past the end of the program
  endfunction

  task automatic emit(input logic [31:0] ins, input int t);
    prog[prog_len]    = ins;
    test_of[prog_len] = t;
    prog_len++;
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [4:0]  rs2;
    logic [12:0] off;
    int          base;
    logic [11:0] addrs [4] = '{ADDR_MCAUSE, ADDR_MEPC, ADDR_MSTATUS, ADDR_MTVEC};
    prog_len = 0;
    for (int i = 1; i < 32; i++) begin
      r = $urandom;
      emit({r[31:12], 5'(i), LUI}, 1);  // half of the registers start out negative
    end
    for (int i = 0; i < 200; i++) begin
      r = $urandom;
      case (r[17:15])
        3'd0:    emit(i_type(OP_IMM, 3'b000, r[4:0], r[9:5], r[31:20]), 1);
        3'd1:    emit({r[31:12], r[4:0], LUI}, 1);
        3'd2:    emit(r_type(3'b000, 7'h00, r[4:0], r[9:5], r[14:10]), 1);
        3'd3:    emit(r_type(3'b000, 7'h20, r[4:0], r[9:5], r[14:10]), 1);
        3'd4:    emit(r_type(3'b111, 7'h00, r[4:0], r[9:5], r[14:10]), 1);
        3'd5:    emit(r_type(3'b110, 7'h00, r[4:0], r[9:5], r[14:10]), 1);
        3'd6:    emit(r_type(3'b100, 7'h00, r[4:0], r[9:5], r[14:10]), 1);
        default: emit(r_type(3'b010, 7'h00, r[4:0], r[9:5], r[14:10]), 1);
      endcase
    end
    emit(i_type(OP_IMM, 3'b000, 5'd0, 5'd5, 12'd77), 2);
    emit(r_type(3'b000, 7'h00, 5'd6, 5'd0, 5'd7), 2);
    emit(r_type(3'b000, 7'h00, 5'd8, 5'd9, 5'd0), 2);
    emit(r_type(3'b000, 7'h20, 5'd0, 5'd1, 5'd2), 2);
    for (int c = 0; c < 4; c++) begin
      r = $urandom;
      emit({r[31:12], 5'd20, LUI}, 3);
      emit(i_type(SYSTEM, 3'b001, 5'd21, 5'd20, addrs[c]), 3);
      emit({r[19:0], 5'd22, LUI}, 3);
      emit(i_type(SYSTEM, 3'b010, 5'd23, 5'd22, addrs[c]), 3);
      emit(i_type(SYSTEM, 3'b010, 5'd24, 5'd0, addrs[c]), 3);  // reads back the new value
    end
    base = prog_len * 4;
    r    = $urandom;
    emit(i_type(OP_IMM, 3'b000, 5'd15, 5'd0, 12'(base + 20)), 4);
    emit(i_type(SYSTEM, 3'b001, 5'd0, 5'd15, ADDR_MTVEC), 4);
    emit(i_type(OP_IMM, 3'b000, 5'd17, 5'd0, r[11:0]), 4);
    emit(32'h0000_0073, 4);
    emit(i_type(OP_IMM, 3'b000, 5'd16, 5'd16, 12'd1), 4);  // jumped over by the trap
    emit(i_type(SYSTEM, 3'b010, 5'd18, 5'd0, ADDR_MCAUSE), 4);
    emit(i_type(OP_IMM, 3'b000, 5'd15, 5'd0, 12'(base + 40)), 4);
    emit(i_type(SYSTEM, 3'b001, 5'd0, 5'd15, ADDR_MEPC), 4);
    emit(32'h3020_0073, 4);
    emit(i_type(OP_IMM, 3'b000, 5'd16, 5'd16, 12'd1), 4);  // jumped over by mret
    emit(i_type(OP_IMM, 3'b000, 5'd19, 5'd18, 12'd5), 4);
    // each branch is followed by two slots, so taken and fall-through paths meet again
    for (int i = 0; i < 40; i++) begin
      r   = $urandom;
      rs2 = r[0] ? r[9:5] : r[14:10];
      off = r[1] ? 13'd8 : 13'd12;
      emit({off[12], off[10:5], rs2, r[9:5], 2'b00, r[2], off[4:1], off[11], BRANCH}, 5);
      emit(i_type(OP_IMM, 3'b000, r[24:20], r[29:25], r[31:20]), 5);
      emit(i_type(OP_IMM, 3'b000, r[19:15], r[4:0], r[27:16]), 5);
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors[exp_test]++;
    $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  task automatic report_test(input int t);
    $display("test %s: %0d checks, %0d errors, %s", test_names[t], checks[t], errors[t],
      (errors[t] == 0) ? "passed" : "failed");
  endtask

  initial begin
    int total_checks;
    int total_errors;
    rst_n       = 1'b0;
    instr       = 32'h0000_0013;
    check_valid = 1'b0;
    exp_pc      = RESET_PC;
    exp_wb_en   = 1'b0;
    exp_wb_rd   = '0;
    exp_wb_data = '0;
    exp_test    = 0;
    void'($urandom(32'h27f1));
    build_program();
    end_addr    = 32'(prog_len * 4);
    cycle_limit = prog_len + 50;
    model_reset();
    @(posedge clk);
    repeat (3) begin
      @(negedge clk);
      instr       = fetch(pc);
      check_valid = 1'b1;  // core must hold the reset pc with wb_en low
    end
    @(negedge clk);
    rst_n = 1'b1;
    while (m_pc < end_addr) begin
      if (test_of[m_pc[10:2]] != exp_test) begin
        report_test(exp_test);
      end
      exp_test = test_of[m_pc[10:2]];
      instr    = fetch(pc);
      exec_step(prog[m_pc[10:2]], exp_pc, exp_wb_en, exp_wb_rd, exp_wb_data);
      @(negedge clk);
    end
    check_valid = 1'b0;
    #3;
    report_test(exp_test);
    for (int t = 0; t < 6; t++) begin
      total_checks += checks[t];
      total_errors += errors[t];
    end
    $display("%0d checks run, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  always begin
    @(negedge clk);
    #2;  // outputs have settled on the new instruction
    if (check_valid) begin
      checks[exp_test] += 2;
      if (pc !== exp_pc) begin
        report_mismatch("pc", exp_pc, pc);
      end
      if (wb_en !== exp_wb_en) begin
        report_mismatch("wb_en", 32'(exp_wb_en), 32'(wb_en));
      end
      if (exp_wb_en) begin
        checks[exp_test] += 2;
        if (wb_rd !== exp_wb_rd) begin
          report_mismatch("wb_rd", 32'(exp_wb_rd), 32'(wb_rd));
        end
        if (wb_data !== exp_wb_data) begin
          report_mismatch("wb_data", exp_wb_data, wb_data);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: program did not reach its end within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

endmodule

// File: sources.f
+incdir+.
rv_pkg.sv
alu.sv
decoder.sv
wbu.sv
pc_unit.sv
rv_core.sv
tb_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_core -o tb_core_sim

out=$(./obj_dir/tb_core_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
